// File: verilog/cache_cfg_pkg.sv
/*
 * Cache geometry
 * Sizes of the set-associative cache and the vector types derived from them
 */
package cache_cfg_pkg;

    // Geometry
    localparam int unsigned SETS       = 16;
    localparam int unsigned WAYS       = 4;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned WORD_WIDTH = 32;
    localparam int unsigned TAG_WIDTH  = 8;

    // Index widths
    localparam int unsigned SET_WIDTH      = $clog2(SETS);
    localparam int unsigned WORD_IDX_WIDTH = $clog2(LINE_WORDS);

    typedef logic [SET_WIDTH-1:0]      set_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;

    // One bit per way, one-hot or multi-hot
    typedef logic [WAYS-1:0] way_vec_t;

    typedef logic [WORD_WIDTH-1:0] data_word_t;

    // One enable per byte of a word
    typedef logic [WORD_WIDTH/8-1:0] be_t;

    // Word 0 sits in the low bits
    typedef logic [LINE_WORDS*WORD_WIDTH-1:0] line_t;

endpackage

// File: verilog/cache_ops_pkg.sv
/*
 * Cache controller operations
 * Request opcodes and controller states
 */
package cache_ops_pkg;

    // Requester opcodes
    typedef enum logic [1:0] {
        OP_READ   = 2'd0,
        OP_WRITE  = 2'd1,
        OP_REFILL = 2'd2,
        OP_INVAL  = 2'd3
    } op_e;

    // Controller states
    typedef enum logic [2:0] {
        ST_INIT    = 3'd0,
        ST_IDLE    = 3'd1,
        ST_LOOKUP  = 3'd2,
        ST_RESOLVE = 3'd3,
        ST_ACK     = 3'd4
    } state_e;

endpackage

// File: verilog/memctrl_fsm.sv
/*
 * Memory controller FSM
 * Sweeps the directory after reset, then sequences each request through
 * lookup and resolve, and holds the response through the req/ack handshake
 */
`timescale 1ns/10ps

module memctrl_fsm (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Requester side
    input  logic                     req_i,
    input  cache_ops_pkg::op_e       op_i,
    output logic                     ready_o,
    output logic                     ack_o,
    output logic                     hit_o,
    output cache_cfg_pkg::way_vec_t  way_o,

    // Array status
    input  cache_cfg_pkg::way_vec_t  hit_way_i,
    input  cache_cfg_pkg::way_vec_t  victim_way_i,

    // Array control
    output logic                     dir_init_o,
    output cache_cfg_pkg::set_t      init_set_o,
    output logic                     lookup_o,
    output logic                     dir_fill_o,
    output logic                     dir_clear_o,
    output logic                     data_wr_o,
    output logic                     data_fill_o,
    output logic                     victim_advance_o
);
    import cache_cfg_pkg::*;
    import cache_ops_pkg::*;

    state_e   state_q, state_d;
    set_t     init_set_q;
    logic     hit_q;
    way_vec_t way_q;

    logic     in_resolve;
    logic     req_hit;
    logic     is_refill;

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_INIT: begin
                // Last set of the sweep
                if (init_set_q == set_t'(SETS - 1)) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (req_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_d = ST_RESOLVE;
            end
            ST_RESOLVE: begin
                state_d = ST_ACK;
            end
            ST_ACK: begin
                // Wait for the requester to drop req_i
                if (!req_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    // Init sweep, one set per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_set_q <= '0;
        end else if (state_q == ST_INIT) begin
            init_set_q <= init_set_q + 1'b1;
        end
    end

    assign dir_init_o = (state_q == ST_INIT);
    assign init_set_o = init_set_q;

    assign lookup_o   = (state_q == ST_LOOKUP);

    // Resolve the opcode against the lookup result
    assign in_resolve = (state_q == ST_RESOLVE);
    assign req_hit    = |hit_way_i;
    assign is_refill  = (op_i == OP_REFILL);

    assign dir_fill_o       = in_resolve && is_refill;
    assign data_fill_o      = in_resolve && is_refill;
    assign victim_advance_o = in_resolve && is_refill;
    assign data_wr_o        = in_resolve && (op_i == OP_WRITE) && req_hit;
    assign dir_clear_o      = in_resolve && (op_i == OP_INVAL) && req_hit;

    // Response captured on the way into ST_ACK
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q <= 1'b0;
            way_q <= '0;
        end else if (in_resolve) begin
            hit_q <= is_refill ? 1'b0 : req_hit;
            way_q <= is_refill ? victim_way_i : hit_way_i;
        end
    end

    assign ready_o = (state_q != ST_INIT);
    assign ack_o   = (state_q == ST_ACK);
    assign hit_o   = hit_q;
    assign way_o   = way_q;

endmodule

// File: verilog/dir_array.sv
/*
 * Cache directory
 * Tags and valid bits per set and way, with a registered tag compare
 */
`timescale 1ns/10ps

module dir_array (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Init sweep
    input  logic                     init_i,
    input  cache_cfg_pkg::set_t      init_set_i,

    // Lookup
    input  logic                     lookup_i,
    input  cache_cfg_pkg::set_t      set_i,
    input  cache_cfg_pkg::tag_t      tag_i,

    // Updates
    input  logic                     fill_i,
    input  cache_cfg_pkg::way_vec_t  fill_way_i,
    input  logic                     clear_i,
    input  cache_cfg_pkg::way_vec_t  clear_way_i,

    output cache_cfg_pkg::way_vec_t  hit_way_o,
    output cache_cfg_pkg::way_vec_t  valid_way_o
);
    import cache_cfg_pkg::*;

    tag_t     tag_mem [SETS][WAYS];
    way_vec_t valid_mem [SETS];

    // Lookup registers
    tag_t     req_tag_q;
    tag_t     rd_tag_q [WAYS];
    way_vec_t valid_q;

    // Tag storage
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < WAYS; w++) begin
            if (init_i) begin
                tag_mem[init_set_i][w] <= '0;
            end else if (fill_i && fill_way_i[w]) begin
                tag_mem[set_i][w] <= tag_i;
            end
        end
    end

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
            end
        end else if (init_i) begin
            valid_mem[init_set_i] <= '0;
        end else if (fill_i) begin
            valid_mem[set_i] <= valid_mem[set_i] | fill_way_i;
        end else if (clear_i) begin
            valid_mem[set_i] <= valid_mem[set_i] & ~clear_way_i;
        end
    end

    // Snapshot of the set, held until the next lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (lookup_i) begin
            valid_q <= valid_mem[set_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            req_tag_q <= tag_i;
            for (int w = 0; w < WAYS; w++) begin
                rd_tag_q[w] <= tag_mem[set_i][w];
            end
        end
    end

    // Tag compare
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way_o[w] = valid_q[w] && (rd_tag_q[w] == req_tag_q);
        end
    end

    assign valid_way_o = valid_q;

endmodule

// File: verilog/data_array.sv
/*
 * Cache data array
 * One word store per way, with line fill, byte-masked word write and a
 * registered read selected by the hit way
 */
`timescale 1ns/10ps

module data_array (
    input  logic                       clk_i,

    // Read
    input  logic                       rd_i,
    input  cache_cfg_pkg::set_t        set_i,
    input  cache_cfg_pkg::word_idx_t   word_i,
    input  cache_cfg_pkg::way_vec_t    hit_way_i,

    // Word write
    input  logic                       wr_i,
    input  cache_cfg_pkg::way_vec_t    wr_way_i,
    input  cache_cfg_pkg::data_word_t  wdata_i,
    input  cache_cfg_pkg::be_t         be_i,

    // Line fill
    input  logic                       fill_i,
    input  cache_cfg_pkg::way_vec_t    fill_way_i,
    input  cache_cfg_pkg::line_t       line_i,

    output cache_cfg_pkg::data_word_t  rdata_o
);
    import cache_cfg_pkg::*;

    localparam int unsigned DEPTH = SETS * LINE_WORDS;

    data_word_t mem [WAYS][DEPTH];
    data_word_t rd_q [WAYS];

    // Word address is set then word index
    logic [SET_WIDTH+WORD_IDX_WIDTH-1:0] addr;

    assign addr = {set_i, word_i};

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < WAYS; w++) begin
            if (fill_i && fill_way_i[w]) begin
                for (int k = 0; k < LINE_WORDS; k++) begin
                    mem[w][{set_i, word_idx_t'(k)}] <= line_i[k*WORD_WIDTH +: WORD_WIDTH];
                end
            end else if (wr_i && wr_way_i[w]) begin
                for (int b = 0; b < $bits(be_t); b++) begin
                    if (be_i[b]) begin
                        mem[w][addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Read all ways, pick one afterwards
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_q[w] <= mem[w][addr];
            end
        end
    end

    // Zero when no way hits
    always_comb begin
        rdata_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            rdata_o = rdata_o | (rd_q[w] & {WORD_WIDTH{hit_way_i[w]}});
        end
    end

endmodule

// File: verilog/victim_select.sv
/*
 * Victim way selection
 * Lowest invalid way first, otherwise a per-set round-robin pointer
 */
`timescale 1ns/10ps

module victim_select (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  cache_cfg_pkg::set_t      set_i,
    input  cache_cfg_pkg::way_vec_t  valid_way_i,
    input  logic                     advance_i,
    output cache_cfg_pkg::way_vec_t  victim_way_o
);
    import cache_cfg_pkg::*;

    // One-hot pointer per set
    way_vec_t ptr_q [SETS];

    way_vec_t first_invalid;
    logic     all_valid;

    assign all_valid = &valid_way_i;

    // Scan down so the lowest invalid way wins
    always_comb begin
        first_invalid = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_way_i[w]) begin
                first_invalid    = '0;
                first_invalid[w] = 1'b1;
            end
        end
    end

    assign victim_way_o = all_valid ? ptr_q[set_i] : first_invalid;

    // Pointer moves only when it was the one used
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < SETS; s++) begin
                ptr_q[s] <= way_vec_t'(1);
            end
        end else if (advance_i && all_valid) begin
            ptr_q[set_i] <= {ptr_q[set_i][WAYS-2:0], ptr_q[set_i][WAYS-1]};
        end
    end

endmodule

// File: verilog/cache_memctrl.sv
/*
 * Cache memory controller
 * Directory, data array and victim choice behind a four-phase req/ack
 * handshake, one request at a time
 */
`timescale 1ns/10ps

module cache_memctrl (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    // Request
    input  logic                       req_i,
    input  cache_ops_pkg::op_e         op_i,
    input  cache_cfg_pkg::set_t        set_i,
    input  cache_cfg_pkg::tag_t        tag_i,
    input  cache_cfg_pkg::word_idx_t   word_i,
    input  cache_cfg_pkg::data_word_t  wdata_i,
    input  cache_cfg_pkg::be_t         be_i,
    input  cache_cfg_pkg::line_t       line_i,

    // Response
    output logic                       ready_o,
    output logic                       ack_o,
    output logic                       hit_o,
    output cache_cfg_pkg::way_vec_t    way_o,
    output cache_cfg_pkg::data_word_t  rdata_o
);
    import cache_cfg_pkg::*;

    logic     dir_init;
    set_t     init_set;
    logic     lookup;
    logic     dir_fill;
    logic     dir_clear;
    logic     data_wr;
    logic     data_fill;
    logic     victim_advance;

    way_vec_t hit_way;
    way_vec_t valid_way;
    way_vec_t victim_way;

    memctrl_fsm u_fsm (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_i            (req_i),
        .op_i             (op_i),
        .ready_o          (ready_o),
        .ack_o            (ack_o),
        .hit_o            (hit_o),
        .way_o            (way_o),
        .hit_way_i        (hit_way),
        .victim_way_i     (victim_way),
        .dir_init_o       (dir_init),
        .init_set_o       (init_set),
        .lookup_o         (lookup),
        .dir_fill_o       (dir_fill),
        .dir_clear_o      (dir_clear),
        .data_wr_o        (data_wr),
        .data_fill_o      (data_fill),
        .victim_advance_o (victim_advance)
    );

    // Invalidate clears the way that hit
    dir_array u_dir (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .init_i      (dir_init),
        .init_set_i  (init_set),
        .lookup_i    (lookup),
        .set_i       (set_i),
        .tag_i       (tag_i),
        .fill_i      (dir_fill),
        .fill_way_i  (victim_way),
        .clear_i     (dir_clear),
        .clear_way_i (hit_way),
        .hit_way_o   (hit_way),
        .valid_way_o (valid_way)
    );

    // Read shares the directory lookup strobe
    data_array u_data (
        .clk_i      (clk_i),
        .rd_i       (lookup),
        .set_i      (set_i),
        .word_i     (word_i),
        .hit_way_i  (hit_way),
        .wr_i       (data_wr),
        .wr_way_i   (hit_way),
        .wdata_i    (wdata_i),
        .be_i       (be_i),
        .fill_i     (data_fill),
        .fill_way_i (victim_way),
        .line_i     (line_i),
        .rdata_o    (rdata_o)
    );

    victim_select u_victim (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .set_i        (set_i),
        .valid_way_i  (valid_way),
        .advance_i    (victim_advance),
        .victim_way_o (victim_way)
    );

endmodule

// File: dv/memctrl_checker.sv
/*
 * Cache controller checker
 * Reference model of tags, valid bits, data and round-robin pointers,
 * compared with every response, plus init sweep and req/ack handshake checks
 */
`timescale 1ns/10ps

module memctrl_checker (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       req_i,
    input  cache_ops_pkg::op_e         op_i,
    input  cache_cfg_pkg::set_t        set_i,
    input  cache_cfg_pkg::tag_t        tag_i,
    input  cache_cfg_pkg::word_idx_t   word_i,
    input  cache_cfg_pkg::data_word_t  wdata_i,
    input  cache_cfg_pkg::be_t         be_i,
    input  cache_cfg_pkg::line_t       line_i,
    input  logic                       ready_i,
    input  logic                       ack_i,
    input  logic                       hit_i,
    input  cache_cfg_pkg::way_vec_t    way_i,
    input  cache_cfg_pkg::data_word_t  rdata_i,
    output int                         errors_o,
    output int                         checks_o
);
    import cache_cfg_pkg::*;
    import cache_ops_pkg::*;

    // Model state
    tag_t       tags [SETS][WAYS];
    logic       valid [SETS][WAYS];
    data_word_t words [SETS][WAYS][LINE_WORDS];
    int         rr_ptr [SETS];

    logic       prev_ack;
    logic       prev_req;
    logic       prev_hit;
    way_vec_t   prev_way;
    int         init_cycles;
    logic       ready_seen;
    int         errors = 0;
    int         checks = 0;

    assign errors_o = errors;
    assign checks_o = checks;

    function automatic void reset_model();
        for (int s = 0; s < SETS; s++) begin
            rr_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                valid[s][w] = 1'b0;
            end
        end
    endfunction

    // Applies one request to the model and returns the expected response
    function automatic void predict(input op_e op, input set_t s, input tag_t t,
                                    input word_idx_t wd, input data_word_t wdata,
                                    input be_t be, input line_t line,
                                    output logic exp_hit, output way_vec_t exp_way,
                                    output data_word_t exp_rdata);
        int hit_w;
        int victim;
        hit_w     = -1;
        victim    = -1;
        exp_hit   = 1'b0;
        exp_way   = '0;
        exp_rdata = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid[s][w] && tags[s][w] == t) begin
                hit_w = w;
            end
        end
        if (op == OP_REFILL) begin
            // Lowest invalid way, else the set's pointer
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!valid[s][w]) begin
                    victim = w;
                end
            end
            if (victim < 0) begin
                victim    = rr_ptr[s];
                rr_ptr[s] = (rr_ptr[s] + 1) % WAYS;
            end
            tags[s][victim]  = t;
            valid[s][victim] = 1'b1;
            for (int k = 0; k < LINE_WORDS; k++) begin
                words[s][victim][k] = line[k*WORD_WIDTH +: WORD_WIDTH];
            end
            exp_way[victim] = 1'b1;
        end else if (hit_w >= 0) begin
            exp_hit        = 1'b1;
            exp_way[hit_w] = 1'b1;
            exp_rdata      = words[s][hit_w][wd];
            if (op == OP_WRITE) begin
                for (int b = 0; b < $bits(be_t); b++) begin
                    if (be[b]) begin
                        words[s][hit_w][wd][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
            end else if (op == OP_INVAL) begin
                valid[s][hit_w] = 1'b0;
            end
        end
    endfunction

    task automatic compare_response();
        logic       exp_hit;
        way_vec_t   exp_way;
        data_word_t exp_rdata;
        predict(op_i, set_i, tag_i, word_i, wdata_i, be_i, line_i,
                exp_hit, exp_way, exp_rdata);
        checks++;
        if (hit_i !== exp_hit) begin
            $display("error hit_o: expected %h, actual %h", exp_hit, hit_i);
            errors++;
        end
        if (way_i !== exp_way) begin
            $display("error way_o: expected %h, actual %h", exp_way, way_i);
            errors++;
        end
        // Read data is only defined for reads
        if (op_i == OP_READ && rdata_i !== exp_rdata) begin
            $display("error rdata_o: expected %h, actual %h", exp_rdata, rdata_i);
            errors++;
        end
    endtask

    // Outputs quiet after reset, ready_o after one cycle per set
    task automatic check_init();
        if (init_cycles == 0 && (ready_i || ack_i || hit_i)) begin
            $display("ready_o, ack_o or hit_o is not low after reset");
            errors++;
        end
        if (ready_i) begin
            ready_seen = 1'b1;
            checks++;
            if (init_cycles != SETS) begin
                $display("error ready_o rise cycles: expected %h, actual %h",
                         SETS, init_cycles);
                errors++;
            end
        end else begin
            init_cycles++;
        end
    endtask

    task automatic check_handshake();
        if (ack_i && !ready_i) begin
            $display("ack_o is high while ready_o is still low");
            errors++;
        end
        if (prev_ack && prev_req && !ack_i) begin
            $display("ack_o dropped while req_i was still held");
            errors++;
        end
        if (prev_ack && !prev_req && ack_i) begin
            $display("ack_o stayed high in the cycle after req_i dropped");
            errors++;
        end
        if (prev_ack && ack_i && (hit_i !== prev_hit || way_i !== prev_way)) begin
            $display("hit_o or way_o changed while ack_o was high");
            errors++;
        end
    endtask

    // Sampled at the rising edge, inputs change 1 ns later
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reset_model();
            prev_ack    = 1'b0;
            prev_req    = 1'b0;
            prev_hit    = 1'b0;
            prev_way    = '0;
            init_cycles = 0;
            ready_seen  = 1'b0;
        end else begin
            if (!ready_seen) begin
                check_init();
            end
            check_handshake();
            if (ack_i && !prev_ack) begin
                compare_response();
            end
            prev_ack = ack_i;
            prev_req = req_i;
            prev_hit = hit_i;
            prev_way = way_i;
        end
    end

endmodule

// File: dv/tb_cache_memctrl.sv
/*
 * Cache memory controller testbench
 * Directed and random req/ack transactions against the DUT, checked by
 * memctrl_checker, with a cycle limit on the whole run
 */
`timescale 1ns/10ps

module tb_cache_memctrl;
    import cache_cfg_pkg::*;
    import cache_ops_pkg::*;

    localparam int unsigned TIMEOUT_CYCLES = 4000;
    localparam int unsigned RANDOM_OPS     = 200;

    logic       clk;
    logic       rst_n;
    logic       req;
    op_e        op;
    set_t       set_idx;
    tag_t       tag;
    word_idx_t  word;
    data_word_t wdata;
    be_t        be;
    line_t      line;
    logic       ready;
    logic       ack;
    logic       hit;
    way_vec_t   way;
    data_word_t rdata;

    integer     seed;
    int         cycle_count = 0;
    int         chk_errors;
    int         chk_checks;

    always #50 clk = ~clk;

    cache_memctrl dut_i (
        .clk_i   (clk),
        .rst_ni  (rst_n),
        .req_i   (req),
        .op_i    (op),
        .set_i   (set_idx),
        .tag_i   (tag),
        .word_i  (word),
        .wdata_i (wdata),
        .be_i    (be),
        .line_i  (line),
        .ready_o (ready),
        .ack_o   (ack),
        .hit_o   (hit),
        .way_o   (way),
        .rdata_o (rdata)
    );

    memctrl_checker u_checker (
        .clk_i    (clk),
        .rst_ni   (rst_n),
        .req_i    (req),
        .op_i     (op),
        .set_i    (set_idx),
        .tag_i    (tag),
        .word_i   (word),
        .wdata_i  (wdata),
        .be_i     (be),
        .line_i   (line),
        .ready_i  (ready),
        .ack_i    (ack),
        .hit_i    (hit),
        .way_i    (way),
        .rdata_i  (rdata),
        .errors_o (chk_errors),
        .checks_o (chk_checks)
    );

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic data_word_t rand_word();
        return $random(seed);
    endfunction

    function automatic be_t rand_be();
        data_word_t r;
        r = $random(seed);
        return r[3:0];
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int k = 0; k < LINE_WORDS; k++) begin
            l[k*WORD_WIDTH +: WORD_WIDTH] = $random(seed);
        end
        return l;
    endfunction

    // One four-phase transaction, req held 0 to 3 cycles past ack
    task automatic run_txn(input op_e t_op, input set_t t_set, input tag_t t_tag,
                           input word_idx_t t_word, input data_word_t t_wdata,
                           input be_t t_be, input line_t t_line);
        int hold;
        while (!ready || ack) begin
            @(posedge clk);
            #1;
        end
        op      = t_op;
        set_idx = t_set;
        tag     = t_tag;
        word    = t_word;
        wdata   = t_wdata;
        be      = t_be;
        line    = t_line;
        req     = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        hold = {$random(seed)} % 4;
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (ack);
    endtask

    task automatic read_word(input set_t s, input tag_t t, input word_idx_t w);
        run_txn(OP_READ, s, t, w, '0, '0, '0);
    endtask

    task automatic write_word(input set_t s, input tag_t t, input word_idx_t w,
                              input data_word_t d, input be_t b);
        run_txn(OP_WRITE, s, t, w, d, b, '0);
    endtask

    task automatic refill_line(input set_t s, input tag_t t, input line_t l);
        run_txn(OP_REFILL, s, t, '0, '0, '0, l);
    endtask

    task automatic invalidate_line(input set_t s, input tag_t t);
        run_txn(OP_INVAL, s, t, '0, '0, '0, '0);
    endtask

    task automatic directed_tests();
        // Empty cache, then refill and read back the whole line
        read_word(4'd0, 8'h3c, 2'd0);
        refill_line(4'd1, 8'h21, rand_line());
        for (int k = 0; k < LINE_WORDS; k++) begin
            read_word(4'd1, 8'h21, word_idx_t'(k));
        end
        // Masked writes that hit, then one that misses
        for (int k = 0; k < LINE_WORDS; k++) begin
            write_word(4'd1, 8'h21, word_idx_t'(k), rand_word(), rand_be());
            read_word(4'd1, 8'h21, word_idx_t'(k));
        end
        write_word(4'd1, 8'h5a, 2'd2, rand_word(), 4'hf);
        read_word(4'd1, 8'h21, 2'd2);
        // Six refills into one set wrap round robin
        for (int t = 0; t < 6; t++) begin
            refill_line(4'd3, tag_t'(8'h40 + t), rand_line());
        end
        read_word(4'd3, 8'h40, 2'd0);
        read_word(4'd3, 8'h41, 2'd1);
        read_word(4'd3, 8'h45, 2'd3);
        // Invalidate frees a way for the next refill
        for (int t = 0; t < WAYS; t++) begin
            refill_line(4'd5, tag_t'(8'h60 + t), rand_line());
        end
        invalidate_line(4'd5, 8'h62);
        read_word(4'd5, 8'h62, 2'd1);
        invalidate_line(4'd5, 8'h70);
        refill_line(4'd5, 8'h71, rand_line());
        read_word(4'd5, 8'h71, 2'd3);
    endtask

    // Few sets and tags so hits and evictions both happen
    task automatic random_mix();
        data_word_t r;
        op_e        r_op;
        set_t       r_set;
        tag_t       r_tag;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r     = rand_word();
            r_op  = op_e'(r[1:0]);
            r_set = set_t'({2'b00, r[3:2]});
            r_tag = tag_t'({5'b00000, r[6:4]});
            case (r_op)
                OP_READ:  read_word(r_set, r_tag, r[8:7]);
                OP_WRITE: write_word(r_set, r_tag, r[8:7], rand_word(), rand_be());
                OP_REFILL: begin
                    // Tag must not be present before a refill
                    invalidate_line(r_set, r_tag);
                    refill_line(r_set, r_tag, rand_line());
                end
                default:  invalidate_line(r_set, r_tag);
            endcase
        end
    endtask

    initial begin
        seed    = 41287;
        clk     = 1'b0;
        rst_n   = 1'b0;
        req     = 1'b0;
        op      = OP_READ;
        set_idx = '0;
        tag     = '0;
        word    = '0;
        wdata   = '0;
        be      = '0;
        line    = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        directed_tests();
        random_mix();
        repeat (2) @(posedge clk);
        #1;
        $display("checks %0d, errors %0d", chk_checks, chk_errors);
        if (chk_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: cache_memctrl.f
verilog/cache_cfg_pkg.sv
verilog/cache_ops_pkg.sv
verilog/memctrl_fsm.sv
verilog/dir_array.sv
verilog/data_array.sv
verilog/victim_select.sv
verilog/cache_memctrl.sv
dv/memctrl_checker.sv
dv/tb_cache_memctrl.sv
